//--- bench/coproc_vectors.txt
// Per line one frame: 32 bytes of A (8 rows by 4 columns, row-major), 4 bytes of B
// then the 8 expected results, bits 15:8 of each row dot product, all in hex
FF FF FF FF 01 01 01 01 00 00 00 00 80 00 00 00 40 40 40 40 41 40 40 40 41 41 40 40 A0 A0 A0 A0 FF FF FF FF F8 03 00 7F FF FF 00 7D
01 02 03 04 10 20 30 40 FF 00 00 00 00 00 00 FF FF FF FF FF 80 80 80 80 12 34 56 78 00 01 00 01 10 20 40 80 03 31 0F 7F EF 78 59 00
FF FF FF FF 10 10 10 10 C8 64 32 19 00 FF 00 FF 80 40 20 10 0A 14 1E 28 33 66 99 CC AB CD EF 01 03 05 07 0B 19 01 06 0F 04 03 0F 0C
01 01 01 01 FF 00 00 00 00 FF 00 00 00 00 FF 00 00 00 00 FF FF FF FF FF 80 80 00 80 02 04 08 10 C0 7F 01 FE 02 BF 7E 00 FD 3B 1E 13

//--- bench/tb_coproc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector coprocessor testbench
// Replays the frames of the vector file through the
// input stream and checks the 8 result words of each
// under input stalls and output back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "coproc_defs.svh"

module tb_coproc;

	localparam int CLK_PERIOD  = 20;
	localparam int IN_WORDS    = `COPROC_IN_WORDS;
	localparam int OUT_WORDS   = `COPROC_OUT_WORDS;
	localparam int FRAME_BYTES = `COPROC_IN_WORDS + `COPROC_OUT_WORDS;
	// Test passes that run every frame of the file
	localparam int FRAME_RUNS  = 4;

	logic                     ACLK;
	logic                     ARESETN;
	logic [`COPROC_BUS_W-1:0] s_axis_tdata;
	logic                     s_axis_tvalid;
	logic                     s_axis_tready;
	logic [`COPROC_BUS_W-1:0] m_axis_tdata;
	logic                     m_axis_tvalid;
	logic                     m_axis_tready;
	logic                     m_axis_tlast;

	// Stimulus bytes and expected results, 44 per frame
	logic [7:0] vec_bytes [$];
	int         num_frames;
	bit         vectors_ready;

	int error_count;
	int test_count;
	int tests_failed;
	// Chance of an idle input cycle and of output ready, in percent
	int gap_percent;
	int ready_percent;

	coproc_top UUT (
		.ACLK          (ACLK),
		.ARESETN       (ARESETN),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tlast  (m_axis_tlast)
	);

	initial ACLK = 1'b0;
	always #(CLK_PERIOD / 2) ACLK = ~ACLK;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("Test %0d %s: PASS", test_count, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAIL with %0d errors", test_count, name,
				error_count - errors_before);
		end
	endtask

	// Two header lines, then one hex byte per token
	task automatic load_vectors();
		int          fd;
		int          code;
		string       line;
		logic [31:0] value;
		fd = $fopen("bench/coproc_vectors.txt", "r");
		if (fd == 0) begin
			report_error("cannot open the vector file bench/coproc_vectors.txt");
			return;
		end
		code = $fgets(line, fd);
		code = $fgets(line, fd);
		code = $fscanf(fd, "%h", value);
		while (code == 1) begin
			vec_bytes.push_back(value[7:0]);
			code = $fscanf(fd, "%h", value);
		end
		$fclose(fd);
		num_frames = vec_bytes.size() / FRAME_BYTES;
		if (num_frames == 0 || vec_bytes.size() % FRAME_BYTES != 0) begin
			report_error("the vector file does not hold whole frames of 44 bytes");
		end
	endtask

	task automatic check_outputs_idle();
		check_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
		check_value("m_axis_tvalid", 32'(m_axis_tvalid), 32'd0);
		check_value("m_axis_tlast", 32'(m_axis_tlast), 32'd0);
	endtask

	// Outputs sampled at the falling edge, away from the register updates
	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < 3; i++) begin
			@(posedge ACLK);
			if (i == 2) begin
				ARESETN <= 1'b1;
			end
			@(negedge ACLK);
			check_outputs_idle();
		end
		// Released, still no input offered
		repeat (2) begin
			@(negedge ACLK);
			check_outputs_idle();
		end
		report_test("reset state", errors_before);
	endtask

	// Input words go out with random gaps and junk in bits 31:8
	task automatic send_frame(input int f);
		int          k;
		logic [31:0] junk;
		k = 0;
		while (k < IN_WORDS) begin
			@(posedge ACLK);
			// No result may appear while the frame is still loading
			check_value("m_axis_tvalid", 32'(m_axis_tvalid), 32'd0);
			if (s_axis_tvalid && s_axis_tready) begin
				k++;
			end
			if (k == IN_WORDS) begin
				s_axis_tvalid <= 1'b0;
			end else if (!s_axis_tvalid || s_axis_tready) begin
				// An offered word stays until accepted
				if ($urandom_range(99) < gap_percent) begin
					s_axis_tvalid <= 1'b0;
				end else begin
					junk = $urandom();
					s_axis_tvalid <= 1'b1;
					s_axis_tdata  <= {junk[31:8], vec_bytes[f * FRAME_BYTES + k]};
				end
			end
		end
	endtask

	// Collects the 8 result words and checks data, tlast and holding
	task automatic receive_frame(input int f);
		int          n;
		logic        holding;
		logic [31:0] hold_data;
		logic [7:0]  expected;
		n       = 0;
		holding = 1'b0;
		while (n < OUT_WORDS) begin
			@(posedge ACLK);
			if (holding) begin
				if (!m_axis_tvalid) begin
					report_error("m_axis_tvalid dropped before its word was accepted");
				end
				check_value("m_axis_tdata while stalled", m_axis_tdata, hold_data);
			end
			if (m_axis_tvalid && m_axis_tready) begin
				expected = vec_bytes[f * FRAME_BYTES + IN_WORDS + n];
				check_value("m_axis_tdata", m_axis_tdata, {24'd0, expected});
				check_value("m_axis_tlast", 32'(m_axis_tlast), 32'(n == OUT_WORDS - 1));
				n++;
				holding = 1'b0;
			end else begin
				holding   = m_axis_tvalid;
				hold_data = m_axis_tdata;
			end
			m_axis_tready <= ($urandom_range(99) < ready_percent);
		end
	endtask

	// Every frame back to back, each one started after the previous tlast
	task automatic run_frames(input string name, input int gap, input int ready);
		int errors_before;
		int f;
		errors_before = error_count;
		gap_percent   = gap;
		ready_percent = ready;
		for (f = 0; f < num_frames; f++) begin
			send_frame(f);
			receive_frame(f);
		end
		// Nothing extra after the last word
		repeat (4) begin
			@(posedge ACLK);
			check_value("m_axis_tvalid after frame", 32'(m_axis_tvalid), 32'd0);
		end
		report_test(name, errors_before);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(18497));
		ARESETN       <= 1'b0;
		s_axis_tdata  <= '0;
		s_axis_tvalid <= 1'b0;
		m_axis_tready <= 1'b0;
		error_count   = 0;
		test_count    = 0;
		tests_failed  = 0;
		load_vectors();
		vectors_ready = 1'b1;
		test_reset();
		run_frames("continuous input, ready held high", 0, 100);
		run_frames("random input stalls", 40, 100);
		run_frames("random output back-pressure", 0, 50);
		run_frames("input stalls with back-pressure", 30, 60);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", test_count,
			test_count - tests_failed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog, 200 cycles per frame run plus a margin for reset and idle tails
	initial begin
		wait (vectors_ready);
		repeat (FRAME_RUNS * num_frames * 200 + 200) @(posedge ACLK);
		$display("Timeout: the run did not finish within %0d clock cycles",
			FRAME_RUNS * num_frames * 200 + 200);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
# Builds the coprocessor testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_coproc --Mdir obj_dir -o sim_coproc

result=$(./obj_dir/sim_coproc)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -q 'All tests passed!'; then
	exit 0
else
	echo "Simulation reported failures"
	exit 1
fi

//--- src.f
+incdir+src
src/coproc_pkg.sv
src/ram_if.sv
src/matrix_ram.sv
src/coproc_ctrl.sv
src/mac_engine.sv
src/result_streamer.sv
src/coproc_top.sv
bench/tb_coproc.sv

//--- src/coproc_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor frame controller
// Accepts the 36 word input stream, loads A and B,
// then sequences the MAC engine and the result stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "coproc_defs.svh"

module coproc_ctrl (
	input  logic                     ACLK,
	input  logic                     ARESETN,
	input  logic [`COPROC_BUS_W-1:0] s_axis_tdata,
	input  logic                     s_axis_tvalid,
	output logic                     s_axis_tready,
	ram_if.writer                    a_wr,
	ram_if.writer                    b_wr,
	output logic                     mac_start,
	input  logic                     mac_done,
	output logic                     out_start,
	input  logic                     out_done
);
	import coproc_pkg::*;

	// Word index of the last input word
	localparam in_count_t LAST_WORD = in_count_t'(`COPROC_IN_WORDS - 1);
	// First word index that belongs to B
	localparam in_count_t A_WORDS = in_count_t'(`COPROC_A_WORDS);

	ctrl_state_t state;
	in_count_t   in_count;
	logic        in_xfer;
	data_t       in_byte;

	// Input handshake
	assign in_xfer = s_axis_tvalid && s_axis_tready;
	// Only the low byte of each bus word carries data
	assign in_byte = s_axis_tdata[`COPROC_DATA_W-1:0];

	// FSM, ready, write enables and start pulses
	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			state         <= IDLE;
			in_count      <= '0;
			s_axis_tready <= 1'b0;
			mac_start     <= 1'b0;
			out_start     <= 1'b0;
			a_wr.wr_en    <= 1'b0;
			b_wr.wr_en    <= 1'b0;
		end else begin
			// Pulses last one cycle
			mac_start  <= 1'b0;
			out_start  <= 1'b0;
			a_wr.wr_en <= 1'b0;
			b_wr.wr_en <= 1'b0;
			case (state)
				IDLE: begin
					// Leave Idle only once the source offers a word
					if (s_axis_tvalid) begin
						state         <= READ_INPUTS;
						s_axis_tready <= 1'b1;
						in_count      <= '0;
					end
				end
				READ_INPUTS: begin
					if (in_xfer) begin
						in_count <= in_count + 1'b1;
						// Words 0..31 fill A, 32..35 fill B
						if (in_count < A_WORDS) begin
							a_wr.wr_en <= 1'b1;
						end else begin
							b_wr.wr_en <= 1'b1;
						end
						// Frame complete, last B write lands with mac_start
						if (in_count == LAST_WORD) begin
							s_axis_tready <= 1'b0;
							mac_start     <= 1'b1;
							state         <= COMPUTE;
						end
					end
				end
				COMPUTE: begin
					// Results are all in RAM by the done edge
					if (mac_done) begin
						state     <= WRITE_OUTPUTS;
						out_start <= 1'b1;
					end
				end
				WRITE_OUTPUTS: begin
					// Done comes with the eighth output transfer
					if (out_done) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Write address and data, captured with the transfer
	always_ff @(posedge ACLK) begin
		if (in_xfer) begin
			a_wr.wr_addr <= a_addr_t'(in_count);
			a_wr.wr_data <= in_byte;
			// B index relative to the end of A
			b_wr.wr_addr <= b_addr_t'(in_count - A_WORDS);
			b_wr.wr_data <= in_byte;
		end
	end

endmodule

//--- src/coproc_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector coprocessor sizes
// Element, bus and matrix dimensions plus
// the counts and address widths derived from them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef COPROC_DEFS_SVH
`define COPROC_DEFS_SVH

// Element and stream widths
`define COPROC_DATA_W     8
`define COPROC_BUS_W      32

// A is 8 rows by 4 columns, B is a 4 element vector
`define COPROC_A_ROWS     8
`define COPROC_A_COLS     4
`define COPROC_A_WORDS    32
`define COPROC_B_WORDS    4

// Frame lengths on both streams
`define COPROC_IN_WORDS   36
`define COPROC_OUT_WORDS  8

// RAM address widths
`define COPROC_A_AW       5
`define COPROC_B_AW       2
`define COPROC_RES_AW     3

// Exact sum of four 16 bit products
`define COPROC_ACC_W      18

`endif

//--- src/coproc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector coprocessor types
// Data, accumulator, address and FSM state types
// shared by all coprocessor blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package coproc_pkg;

	`include "coproc_defs.svh"

	// One matrix or vector element
	typedef logic [`COPROC_DATA_W-1:0] data_t;

	// Row dot product accumulator
	typedef logic [`COPROC_ACC_W-1:0] acc_t;

	// RAM addresses
	typedef logic [`COPROC_A_AW-1:0] a_addr_t;
	typedef logic [`COPROC_B_AW-1:0] b_addr_t;
	typedef logic [`COPROC_RES_AW-1:0] res_addr_t;

	// Counts 0 to 36 accepted input words
	typedef logic [$clog2(`COPROC_IN_WORDS + 1)-1:0] in_count_t;

	// Frame controller FSM
	typedef enum logic [1:0] {
		IDLE          = 2'd0,
		READ_INPUTS   = 2'd1,
		COMPUTE       = 2'd2,
		WRITE_OUTPUTS = 2'd3
	} ctrl_state_t;

endpackage

//--- src/coproc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector coprocessor top
// Stream ports, A, B and result RAMs, controller,
// MAC engine and result streamer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "coproc_defs.svh"

module coproc_top (
	input  logic                     ACLK,
	input  logic                     ARESETN,
	input  logic [`COPROC_BUS_W-1:0] s_axis_tdata,
	input  logic                     s_axis_tvalid,
	output logic                     s_axis_tready,
	output logic [`COPROC_BUS_W-1:0] m_axis_tdata,
	output logic                     m_axis_tvalid,
	input  logic                     m_axis_tready,
	output logic                     m_axis_tlast
);

	// Control pulses between the blocks
	logic mac_start;
	logic mac_done;
	logic out_start;
	logic out_done;

	// One port bundle per RAM
	ram_if #(.ADDR_W(`COPROC_A_AW))   a_bus ();
	ram_if #(.ADDR_W(`COPROC_B_AW))   b_bus ();
	ram_if #(.ADDR_W(`COPROC_RES_AW)) res_bus ();

	// A matrix, 32 elements
	matrix_ram #(.DEPTH_BITS(`COPROC_A_AW)) a_ram (
		.ACLK (ACLK),
		.mem  (a_bus.mem)
	);

	// B vector, 4 elements
	matrix_ram #(.DEPTH_BITS(`COPROC_B_AW)) b_ram (
		.ACLK (ACLK),
		.mem  (b_bus.mem)
	);

	// Results, one per row of A
	matrix_ram #(.DEPTH_BITS(`COPROC_RES_AW)) res_ram (
		.ACLK (ACLK),
		.mem  (res_bus.mem)
	);

	coproc_ctrl u_ctrl (
		.ACLK          (ACLK),
		.ARESETN       (ARESETN),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.a_wr          (a_bus.writer),
		.b_wr          (b_bus.writer),
		.mac_start     (mac_start),
		.mac_done      (mac_done),
		.out_start     (out_start),
		.out_done      (out_done)
	);

	mac_engine u_mac (
		.ACLK    (ACLK),
		.ARESETN (ARESETN),
		.start   (mac_start),
		.done    (mac_done),
		.a_rd    (a_bus.reader),
		.b_rd    (b_bus.reader),
		.res_wr  (res_bus.writer)
	);

	result_streamer u_out (
		.ACLK          (ACLK),
		.ARESETN       (ARESETN),
		.start         (out_start),
		.done          (out_done),
		.res_rd        (res_bus.reader),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tlast  (m_axis_tlast)
	);

endmodule

//--- src/mac_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Row by row multiply-accumulate engine
// Streams A and B out of their RAMs, sums each row
// and writes bits 15:8 of the sum to the result RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "coproc_defs.svh"

module mac_engine (
	input  logic  ACLK,
	input  logic  ARESETN,
	input  logic  start,
	output logic  done,
	ram_if.reader a_rd,
	ram_if.reader b_rd,
	ram_if.writer res_wr
);
	import coproc_pkg::*;

	localparam res_addr_t LAST_ROW = res_addr_t'(`COPROC_A_ROWS - 1);
	localparam b_addr_t   LAST_COL = b_addr_t'(`COPROC_A_COLS - 1);

	// Read issue stage
	logic      busy;
	res_addr_t row;
	b_addr_t   col;

	// RAM data stage, tags follow the reads by one cycle
	logic      v1;
	logic      v1_first;
	logic      v1_last;
	res_addr_t v1_row;

	logic [2*`COPROC_DATA_W-1:0] product;
	acc_t                        acc;
	acc_t                        acc_next;

	// One A,B pair per cycle while busy
	// A is row-major with 4 columns so its address is {row, col}
	assign a_rd.rd_en   = busy;
	assign a_rd.rd_addr = {row, col};
	assign b_rd.rd_en   = busy;
	assign b_rd.rd_addr = col;

	// Walk rows and columns, next row starts straight after the last column
	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			busy <= 1'b0;
			row  <= '0;
			col  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			row  <= '0;
			col  <= '0;
		end else if (busy) begin
			col <= col + 1'b1;
			if (col == LAST_COL) begin
				row <= row + 1'b1;
				if (row == LAST_ROW) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			v1 <= 1'b0;
		end else begin
			v1 <= busy;
		end
	end

	always_ff @(posedge ACLK) begin
		v1_first <= (col == '0);
		v1_last  <= (col == LAST_COL);
		v1_row   <= row;
	end

	// Multiply the RAM outputs and add into the row sum
	// First column restarts the sum
	always_comb begin
		product  = a_rd.rd_data * b_rd.rd_data;
		acc_next = acc_t'(product);
		if (!v1_first) begin
			acc_next = acc + acc_t'(product);
		end
	end

	// Row end writes one result, last row also ends the run
	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			res_wr.wr_en <= 1'b0;
			done         <= 1'b0;
		end else begin
			res_wr.wr_en <= v1 && v1_last;
			done         <= v1 && v1_last && (v1_row == LAST_ROW);
		end
	end

	always_ff @(posedge ACLK) begin
		if (v1) begin
			acc <= acc_next;
		end
		res_wr.wr_addr <= v1_row;
		res_wr.wr_data <= acc_next[2*`COPROC_DATA_W-1:`COPROC_DATA_W];
	end

endmodule

//--- src/matrix_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple dual-port element RAM
// Synchronous write, registered read with enable,
// depth of 2**DEPTH_BITS elements
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module matrix_ram #(
	parameter int DEPTH_BITS = 5
) (
	input logic ACLK,
	ram_if.mem  mem
);
	import coproc_pkg::*;

	localparam int DEPTH = 2 ** DEPTH_BITS;

	// Storage array
	data_t ram [0:DEPTH-1];

	// Write side
	always_ff @(posedge ACLK) begin
		if (mem.wr_en) begin
			ram[mem.wr_addr] <= mem.wr_data;
		end
	end

	// Read side
	// Output holds until the next enabled read
	// Same address write and read returns the old word
	always_ff @(posedge ACLK) begin
		if (mem.rd_en) begin
			mem.rd_data <= ram[mem.rd_addr];
		end
	end

endmodule

//--- src/ram_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM port bundle
// One write port and one registered read port,
// address width set per RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface ram_if #(
	parameter int ADDR_W = 5
);
	import coproc_pkg::*;

	// Write port, takes effect at the edge where wr_en is high
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	data_t             wr_data;

	// Read port, data one cycle after the rd_en edge
	logic              rd_en;
	logic [ADDR_W-1:0] rd_addr;
	data_t             rd_data;

	// Block that fills the RAM
	modport writer (output wr_en, wr_addr, wr_data);

	// Block that consumes the RAM
	modport reader (output rd_en, rd_addr, input rd_data);

	// The RAM itself
	modport mem (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

endinterface

//--- src/result_streamer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stream master
// Reads the result RAM into a two-entry buffer and
// sends 8 zero-extended words with back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "coproc_defs.svh"

module result_streamer (
	input  logic                     ACLK,
	input  logic                     ARESETN,
	input  logic                     start,
	output logic                     done,
	ram_if.reader                    res_rd,
	output logic [`COPROC_BUS_W-1:0] m_axis_tdata,
	output logic                     m_axis_tvalid,
	input  logic                     m_axis_tready,
	output logic                     m_axis_tlast
);
	import coproc_pkg::*;

	localparam res_addr_t LAST_ADDR = res_addr_t'(`COPROC_OUT_WORDS - 1);

	// Read issue side
	logic      issuing;
	res_addr_t next_addr;
	logic      in_flight;
	logic      in_flight_last;

	// Two-entry FIFO, head is what the stream shows
	data_t      buf_data [2];
	logic       buf_last [2];
	logic       head;
	logic       tail;
	logic [1:0] buf_count;

	logic       push;
	logic       pop;
	logic [2:0] fill_after;

	assign push = in_flight;
	assign pop  = m_axis_tvalid && m_axis_tready;

	// Occupancy after this edge, a new read needs it at 1 or less
	assign fill_after = 3'(buf_count) + 3'(in_flight) - 3'(pop);

	// First read goes out in the start cycle itself
	assign res_rd.rd_en   = (start || issuing) && (fill_after <= 3'd1);
	assign res_rd.rd_addr = next_addr;

	assign m_axis_tvalid = (buf_count != 2'd0);
	assign m_axis_tdata  = `COPROC_BUS_W'(buf_data[head]);
	assign m_axis_tlast  = m_axis_tvalid && buf_last[head];
	// Final word accepted
	assign done = pop && buf_last[head];

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			issuing   <= 1'b0;
			next_addr <= '0;
			in_flight <= 1'b0;
			head      <= 1'b0;
			tail      <= 1'b0;
			buf_count <= '0;
		end else begin
			if (start) begin
				issuing <= 1'b1;
			end
			// Address wraps back to 0 after the last read
			if (res_rd.rd_en) begin
				next_addr <= next_addr + 1'b1;
				if (next_addr == LAST_ADDR) begin
					issuing <= 1'b0;
				end
			end
			in_flight <= res_rd.rd_en;
			if (push) begin
				tail <= ~tail;
			end
			if (pop) begin
				head <= ~head;
			end
			buf_count <= buf_count + 2'(push) - 2'(pop);
		end
	end

	// Buffer contents, tagged with the last address flag
	always_ff @(posedge ACLK) begin
		in_flight_last <= (next_addr == LAST_ADDR);
		if (push) begin
			buf_data[tail] <= res_rd.rd_data;
			buf_last[tail] <= in_flight_last;
		end
	end

endmodule
